// File: zynq_bridge.f
verilog/zynq_bridge_pkg.sv
verilog/zynq_pl_shell.sv
verilog/dram_req_issue.sv
verilog/dram_resp_queue.sv
verilog/top_zynq.sv
tb/hp0_mem_model.sv
tb/tb_top_zynq.sv

// File: Makefile
SIM = obj_dir/tb_top_zynq

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_top_zynq \
		-f zynq_bridge.f -Mdir obj_dir -o tb_top_zynq
	@out="$$(./$(SIM))"; echo "$$out"; \
		echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

// File: tb/tb_top_zynq.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top_zynq
   import zynq_bridge_pkg::*;
;

   typedef struct packed {
      dram_addr_t base;
      req_type_t  kind;
      dram_addr_t offset;
      word_t      wdata;
   } entry_t;

   localparam int NUM_ENTRIES    = 19;
   localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 200 + 1000;

   // base, kind, offset, write data
   localparam entry_t REQ_TABLE [NUM_ENTRIES] = '{
      // single requests, base switching
      '{32'h100, REQ_WRITE, 32'h10, 32'hcafe_0001},
      '{32'h100, REQ_READ,  32'h10, 32'h0},
      '{32'h200, REQ_READ,  32'h10, 32'h0},
      '{32'h200, REQ_WRITE, 32'h10, 32'hcafe_0002},
      '{32'h100, REQ_READ,  32'h10, 32'h0},
      '{32'h200, REQ_READ,  32'h10, 32'h0},
      // batch of four before popping
      '{32'h040, REQ_WRITE, 32'h00, 32'h1111_aaaa},
      '{32'h040, REQ_WRITE, 32'h04, 32'h2222_bbbb},
      '{32'h040, REQ_READ,  32'h00, 32'h0},
      '{32'h040, REQ_READ,  32'h08, 32'h0},
      // overflow batch of nine
      '{32'h300, REQ_WRITE, 32'h00, 32'h3333_cccc},
      '{32'h300, REQ_READ,  32'h00, 32'h0},
      '{32'h300, REQ_WRITE, 32'h04, 32'h4444_dddd},
      '{32'h300, REQ_READ,  32'h04, 32'h0},
      '{32'h300, REQ_READ,  32'h0c, 32'h0},
      '{32'h300, REQ_WRITE, 32'h08, 32'h5555_eeee},
      '{32'h300, REQ_READ,  32'h08, 32'h0},
      '{32'h300, REQ_WRITE, 32'h00, 32'h6666_ffff},
      '{32'h300, REQ_READ,  32'h00, 32'h0}
   };

   // pushed when every queue is full, must be dropped
   localparam entry_t EXTRA_REQ = '{32'h300, REQ_WRITE, 32'h3c, 32'hdead_beef};

   logic       aclk = 1'b0;
   logic       rst_n;
   gp0_addr_t  gp0_awaddr;
   logic       gp0_awvalid;
   logic       gp0_awready;
   word_t      gp0_wdata;
   logic       gp0_wvalid;
   logic       gp0_wready;
   logic [1:0] gp0_bresp;
   logic       gp0_bvalid;
   logic       gp0_bready;
   gp0_addr_t  gp0_araddr;
   logic       gp0_arvalid;
   logic       gp0_arready;
   word_t      gp0_rdata;
   logic [1:0] gp0_rresp;
   logic       gp0_rvalid;
   logic       gp0_rready;

   dram_addr_t hp0_awaddr;
   logic       hp0_awvalid;
   logic       hp0_awready;
   word_t      hp0_wdata;
   logic       hp0_wvalid;
   logic       hp0_wready;
   logic [1:0] hp0_bresp;
   logic       hp0_bvalid;
   logic       hp0_bready;
   dram_addr_t hp0_araddr;
   logic       hp0_arvalid;
   logic       hp0_arready;
   word_t      hp0_rdata;
   logic [1:0] hp0_rresp;
   logic       hp0_rvalid;
   logic       hp0_rready;

   word_t      expected [NUM_ENTRIES];

   always #4 aclk = ~aclk;

   top_zynq #(
      .REQ_FIFO_DEPTH  (4),
      .RESP_FIFO_DEPTH (4)
   ) i_top_zynq (
      .aclk_i        (aclk),
      .rst_n_i       (rst_n),
      .gp0_awaddr_i  (gp0_awaddr),
      .gp0_awvalid_i (gp0_awvalid),
      .gp0_awready_o (gp0_awready),
      .gp0_wdata_i   (gp0_wdata),
      .gp0_wvalid_i  (gp0_wvalid),
      .gp0_wready_o  (gp0_wready),
      .gp0_bresp_o   (gp0_bresp),
      .gp0_bvalid_o  (gp0_bvalid),
      .gp0_bready_i  (gp0_bready),
      .gp0_araddr_i  (gp0_araddr),
      .gp0_arvalid_i (gp0_arvalid),
      .gp0_arready_o (gp0_arready),
      .gp0_rdata_o   (gp0_rdata),
      .gp0_rresp_o   (gp0_rresp),
      .gp0_rvalid_o  (gp0_rvalid),
      .gp0_rready_i  (gp0_rready),
      .hp0_awaddr_o  (hp0_awaddr),
      .hp0_awvalid_o (hp0_awvalid),
      .hp0_awready_i (hp0_awready),
      .hp0_wdata_o   (hp0_wdata),
      .hp0_wvalid_o  (hp0_wvalid),
      .hp0_wready_i  (hp0_wready),
      .hp0_bresp_i   (hp0_bresp),
      .hp0_bvalid_i  (hp0_bvalid),
      .hp0_bready_o  (hp0_bready),
      .hp0_araddr_o  (hp0_araddr),
      .hp0_arvalid_o (hp0_arvalid),
      .hp0_arready_i (hp0_arready),
      .hp0_rdata_i   (hp0_rdata),
      .hp0_rresp_i   (hp0_rresp),
      .hp0_rvalid_i  (hp0_rvalid),
      .hp0_rready_o  (hp0_rready)
   );

   hp0_mem_model i_mem (
      .aclk_i    (aclk),
      .rst_n_i   (rst_n),
      .awaddr_i  (hp0_awaddr),
      .awvalid_i (hp0_awvalid),
      .awready_o (hp0_awready),
      .wdata_i   (hp0_wdata),
      .wvalid_i  (hp0_wvalid),
      .wready_o  (hp0_wready),
      .bresp_o   (hp0_bresp),
      .bvalid_o  (hp0_bvalid),
      .bready_i  (hp0_bready),
      .araddr_i  (hp0_araddr),
      .arvalid_i (hp0_arvalid),
      .arready_o (hp0_arready),
      .rdata_o   (hp0_rdata),
      .rresp_o   (hp0_rresp),
      .rvalid_o  (hp0_rvalid),
      .rready_i  (hp0_rready)
   );

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////
   function automatic word_t fill_word(input logic [7:0] idx);
      return {8'h5a, ~idx, idx, idx ^ 8'hc3};
   endfunction

   // status: bit 0 pending, bits 7:4 count
   function automatic word_t status_word(input int n);
      return (word_t'(n) << 4) | word_t'(n != 0);
   endfunction

   function automatic void build_expected();
      word_t      shadow [256];
      logic [7:0] idx;
      for (int i = 0; i < 256; i++) begin
         shadow[i] = fill_word(8'(i));
      end
      for (int e = 0; e < NUM_ENTRIES; e++) begin
         idx = 8'((REQ_TABLE[e].base + REQ_TABLE[e].offset) >> 2);
         if (REQ_TABLE[e].kind == REQ_WRITE) begin
            shadow[idx] = REQ_TABLE[e].wdata;
            // okay status, zero-extended
            expected[e] = '0;
         end else begin
            expected[e] = shadow[idx];
         end
      end
   endfunction

   task automatic expect_word(input word_t got, input word_t exp, input string what);
      assert (got === exp)
         else begin
            $display("CHECK FAILED at %0t ns: %s read %h, expected %h", $time, what, got, exp);
            $display("Verification failed");
            $fatal(1, "stopped at first mismatch");
         end
   endtask

   ////////////////////////////////////////
   // gp0 host side
   ////////////////////////////////////////
   task automatic write_reg(input gp0_addr_t addr, input word_t data, output logic [1:0] resp);
      @(negedge aclk);
      gp0_awaddr  = addr;
      gp0_wdata   = data;
      gp0_awvalid = 1'b1;
      gp0_wvalid  = 1'b1;
      while (!gp0_awready) @(negedge aclk);
      // aw and w ready pulse together
      expect_word(word_t'(gp0_wready), 32'd1, "wready alongside awready");
      // handshake happens on the posedge in between
      @(negedge aclk);
      gp0_awvalid = 1'b0;
      gp0_wvalid  = 1'b0;
      while (!gp0_bvalid) @(negedge aclk);
      resp = gp0_bresp;
   endtask

   task automatic read_reg(input gp0_addr_t addr, output word_t data);
      @(negedge aclk);
      gp0_araddr  = addr;
      gp0_arvalid = 1'b1;
      while (!gp0_arready) @(negedge aclk);
      @(negedge aclk);
      gp0_arvalid = 1'b0;
      while (!gp0_rvalid) @(negedge aclk);
      data = gp0_rdata;
      expect_word(word_t'(gp0_rresp), word_t'(RESP_OKAY), "read response code");
   endtask

   task automatic push_request(input entry_t e, input logic [1:0] exp_resp);
      logic [1:0] resp;
      write_reg(REG_REQ_TYPE, word_t'(e.kind), resp);
      expect_word(word_t'(resp), word_t'(exp_resp), "type push status");
      write_reg(REG_REQ_ADDR, e.offset, resp);
      expect_word(word_t'(resp), word_t'(exp_resp), "offset push status");
      write_reg(REG_REQ_DATA, e.wdata, resp);
      expect_word(word_t'(resp), word_t'(exp_resp), "data push status");
   endtask

   task automatic wait_for_count(input int n);
      word_t st;
      read_reg(REG_STATUS, st);
      while (st[7:4] != 4'(n)) read_reg(REG_STATUS, st);
   endtask

   task automatic pop_response(input int idx);
      word_t st;
      word_t got;
      read_reg(REG_STATUS, st);
      while (!st[0]) read_reg(REG_STATUS, st);
      read_reg(REG_RESP, got);
      expect_word(got, expected[idx], $sformatf("response of entry %0d", idx));
   endtask

   task automatic set_base(input dram_addr_t base);
      logic [1:0] resp;
      write_reg(REG_BASE, base, resp);
      expect_word(word_t'(resp), word_t'(RESP_OKAY), "base write status");
   endtask

   ////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////
   initial begin : main
      word_t rd;
      void'($urandom(32'h57a4));
      rst_n       = 1'b0;
      gp0_awaddr  = '0;
      gp0_awvalid = 1'b0;
      gp0_wdata   = '0;
      gp0_wvalid  = 1'b0;
      gp0_bready  = 1'b1;
      gp0_araddr  = '0;
      gp0_arvalid = 1'b0;
      gp0_rready  = 1'b1;
      build_expected();
      repeat (5) @(posedge aclk);
      @(negedge aclk);
      rst_n = 1'b1;

      // idle status and base readback
      read_reg(REG_STATUS, rd);
      expect_word(rd, '0, "status after reset");
      set_base(32'h1234_5678);
      read_reg(REG_BASE, rd);
      expect_word(rd, 32'h1234_5678, "base readback");
      set_base(32'hffff_fffc);
      read_reg(REG_BASE, rd);
      expect_word(rd, 32'hffff_fffc, "base readback");

      // one request at a time
      for (int i = 0; i < 6; i++) begin
         set_base(REQ_TABLE[i].base);
         push_request(REQ_TABLE[i], RESP_OKAY);
         pop_response(i);
      end

      // four queued, then drained in order
      set_base(REQ_TABLE[6].base);
      for (int i = 6; i < 10; i++) begin
         push_request(REQ_TABLE[i], RESP_OKAY);
      end
      wait_for_count(4);
      read_reg(REG_STATUS, rd);
      expect_word(rd, status_word(4), "status with four responses");
      for (int i = 6; i < 10; i++) begin
         pop_response(i);
      end

      // fill the response queue, then one in flight and four in the fifos
      set_base(REQ_TABLE[10].base);
      for (int i = 10; i < 14; i++) begin
         push_request(REQ_TABLE[i], RESP_OKAY);
      end
      wait_for_count(4);
      for (int i = 14; i < NUM_ENTRIES; i++) begin
         push_request(REQ_TABLE[i], RESP_OKAY);
      end
      push_request(EXTRA_REQ, RESP_SLVERR);
      read_reg(REG_STATUS, rd);
      expect_word(rd, status_word(4), "status under back-pressure");
      for (int i = 10; i < NUM_ENTRIES; i++) begin
         pop_response(i);
      end
      read_reg(REG_STATUS, rd);
      expect_word(rd, '0, "status after drain");

      $display("Verification passed");
      $finish;
   end

   initial begin : watchdog
      repeat (TIMEOUT_CYCLES) @(posedge aclk);
      $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire

// File: tb/hp0_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module hp0_mem_model
   import zynq_bridge_pkg::*;
(
   input  logic       aclk_i,
   input  logic       rst_n_i,

   input  dram_addr_t awaddr_i,
   input  logic       awvalid_i,
   output logic       awready_o,
   input  word_t      wdata_i,
   input  logic       wvalid_i,
   output logic       wready_o,
   output logic [1:0] bresp_o,
   output logic       bvalid_o,
   input  logic       bready_i,
   input  dram_addr_t araddr_i,
   input  logic       arvalid_i,
   output logic       arready_o,
   output word_t      rdata_o,
   output logic [1:0] rresp_o,
   output logic       rvalid_o,
   input  logic       rready_i
);

   word_t      mem [256];
   logic [1:0] aw_wait;
   logic [1:0] b_wait;
   logic [1:0] ar_wait;
   logic [1:0] r_wait;
   logic       wr_busy;
   logic       rd_busy;

   // every word differs, built from its full index
   initial begin
      for (int i = 0; i < 256; i++) begin
         mem[i] = {8'h5a, ~8'(i), 8'(i), 8'(i) ^ 8'hc3};
      end
   end

   assign bresp_o = RESP_OKAY;
   assign rresp_o = RESP_OKAY;

   always @(posedge aclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         awready_o <= 1'b0;
         wready_o  <= 1'b0;
         bvalid_o  <= 1'b0;
         arready_o <= 1'b0;
         rvalid_o  <= 1'b0;
         rdata_o   <= '0;
         aw_wait   <= '0;
         b_wait    <= '0;
         ar_wait   <= '0;
         r_wait    <= '0;
         wr_busy   <= 1'b0;
         rd_busy   <= 1'b0;
      end else begin
         awready_o <= 1'b0;
         wready_o  <= 1'b0;
         arready_o <= 1'b0;

         ////////////////////////////////////////
         // write path
         ////////////////////////////////////////
         if (bvalid_o) begin
            if (bready_i) begin
               bvalid_o <= 1'b0;
            end
         end else if (wr_busy) begin
            if (b_wait == '0) begin
               bvalid_o <= 1'b1;
               wr_busy  <= 1'b0;
            end else begin
               b_wait <= b_wait - 2'd1;
            end
         end else if (awvalid_i && wvalid_i && !awready_o) begin
            if (aw_wait == '0) begin
               // aw and w taken in the same cycle
               awready_o            <= 1'b1;
               wready_o             <= 1'b1;
               mem[awaddr_i[9:2]]   <= wdata_i;
               wr_busy              <= 1'b1;
               b_wait               <= 2'($urandom % 4);
               aw_wait              <= 2'($urandom % 4);
            end else begin
               aw_wait <= aw_wait - 2'd1;
            end
         end

         ////////////////////////////////////////
         // read path
         ////////////////////////////////////////
         if (rvalid_o) begin
            if (rready_i) begin
               rvalid_o <= 1'b0;
            end
         end else if (rd_busy) begin
            if (r_wait == '0) begin
               rvalid_o <= 1'b1;
               rd_busy  <= 1'b0;
            end else begin
               r_wait <= r_wait - 2'd1;
            end
         end else if (arvalid_i && !arready_o) begin
            if (ar_wait == '0) begin
               arready_o <= 1'b1;
               rdata_o   <= mem[araddr_i[9:2]];
               rd_busy   <= 1'b1;
               r_wait    <= 2'($urandom % 4);
               ar_wait   <= 2'($urandom % 4);
            end else begin
               ar_wait <= ar_wait - 2'd1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/top_zynq.sv
`timescale 1ns/1ps
`default_nettype none

module top_zynq
   import zynq_bridge_pkg::*;
#(
   parameter int REQ_FIFO_DEPTH  = 4,
   parameter int RESP_FIFO_DEPTH = 4
) (
   input  logic       aclk_i,
   input  logic       rst_n_i,

   // gp0 slave from the host
   input  gp0_addr_t  gp0_awaddr_i,
   input  logic       gp0_awvalid_i,
   output logic       gp0_awready_o,
   input  word_t      gp0_wdata_i,
   input  logic       gp0_wvalid_i,
   output logic       gp0_wready_o,
   output logic [1:0] gp0_bresp_o,
   output logic       gp0_bvalid_o,
   input  logic       gp0_bready_i,
   input  gp0_addr_t  gp0_araddr_i,
   input  logic       gp0_arvalid_i,
   output logic       gp0_arready_o,
   output word_t      gp0_rdata_o,
   output logic [1:0] gp0_rresp_o,
   output logic       gp0_rvalid_o,
   input  logic       gp0_rready_i,

   // hp0 master to dram
   output dram_addr_t hp0_awaddr_o,
   output logic       hp0_awvalid_o,
   input  logic       hp0_awready_i,
   output word_t      hp0_wdata_o,
   output logic       hp0_wvalid_o,
   input  logic       hp0_wready_i,
   input  logic [1:0] hp0_bresp_i,
   input  logic       hp0_bvalid_i,
   output logic       hp0_bready_o,
   output dram_addr_t hp0_araddr_o,
   output logic       hp0_arvalid_o,
   input  logic       hp0_arready_i,
   input  word_t      hp0_rdata_i,
   input  logic [1:0] hp0_rresp_i,
   input  logic       hp0_rvalid_i,
   output logic       hp0_rready_o
);

   logic       req_v;
   req_type_t  req_type;
   dram_addr_t req_addr;
   word_t      req_data;
   dram_addr_t base;
   logic       req_yumi;
   logic       resp_done;
   logic       resp_v;
   word_t      resp_data;
   logic [3:0] resp_count;
   logic       resp_pop;

   zynq_pl_shell #(
      .REQ_FIFO_DEPTH (REQ_FIFO_DEPTH)
   ) i_shell (
      .aclk_i        (aclk_i),
      .rst_n_i       (rst_n_i),
      .gp0_awaddr_i  (gp0_awaddr_i),
      .gp0_awvalid_i (gp0_awvalid_i),
      .gp0_awready_o (gp0_awready_o),
      .gp0_wdata_i   (gp0_wdata_i),
      .gp0_wvalid_i  (gp0_wvalid_i),
      .gp0_wready_o  (gp0_wready_o),
      .gp0_bresp_o   (gp0_bresp_o),
      .gp0_bvalid_o  (gp0_bvalid_o),
      .gp0_bready_i  (gp0_bready_i),
      .gp0_araddr_i  (gp0_araddr_i),
      .gp0_arvalid_i (gp0_arvalid_i),
      .gp0_arready_o (gp0_arready_o),
      .gp0_rdata_o   (gp0_rdata_o),
      .gp0_rresp_o   (gp0_rresp_o),
      .gp0_rvalid_o  (gp0_rvalid_o),
      .gp0_rready_i  (gp0_rready_i),
      .req_v_o       (req_v),
      .req_type_o    (req_type),
      .req_addr_o    (req_addr),
      .req_data_o    (req_data),
      .req_yumi_i    (req_yumi),
      .base_o        (base),
      .resp_v_i      (resp_v),
      .resp_data_i   (resp_data),
      .resp_count_i  (resp_count),
      .resp_pop_o    (resp_pop)
   );

   dram_req_issue i_issue (
      .aclk_i        (aclk_i),
      .rst_n_i       (rst_n_i),
      .req_v_i       (req_v),
      .req_type_i    (req_type),
      .req_addr_i    (req_addr),
      .req_data_i    (req_data),
      .base_i        (base),
      .req_yumi_o    (req_yumi),
      .hp0_awaddr_o  (hp0_awaddr_o),
      .hp0_awvalid_o (hp0_awvalid_o),
      .hp0_awready_i (hp0_awready_i),
      .hp0_wdata_o   (hp0_wdata_o),
      .hp0_wvalid_o  (hp0_wvalid_o),
      .hp0_wready_i  (hp0_wready_i),
      .hp0_araddr_o  (hp0_araddr_o),
      .hp0_arvalid_o (hp0_arvalid_o),
      .hp0_arready_i (hp0_arready_i),
      .resp_done_i   (resp_done)
   );

   dram_resp_queue #(
      .RESP_FIFO_DEPTH (RESP_FIFO_DEPTH)
   ) i_resp (
      .aclk_i        (aclk_i),
      .rst_n_i       (rst_n_i),
      .hp0_bresp_i   (hp0_bresp_i),
      .hp0_bvalid_i  (hp0_bvalid_i),
      .hp0_bready_o  (hp0_bready_o),
      .hp0_rdata_i   (hp0_rdata_i),
      .hp0_rresp_i   (hp0_rresp_i),
      .hp0_rvalid_i  (hp0_rvalid_i),
      .hp0_rready_o  (hp0_rready_o),
      .resp_done_o   (resp_done),
      .resp_v_o      (resp_v),
      .resp_data_o   (resp_data),
      .resp_count_o  (resp_count),
      .resp_pop_i    (resp_pop)
   );

endmodule

`default_nettype wire

// File: verilog/dram_resp_queue.sv
`timescale 1ns/1ps
`default_nettype none

module dram_resp_queue
   import zynq_bridge_pkg::*;
#(
   parameter int RESP_FIFO_DEPTH = 4
) (
   input  logic       aclk_i,
   input  logic       rst_n_i,

   input  logic [1:0] hp0_bresp_i,
   input  logic       hp0_bvalid_i,
   output logic       hp0_bready_o,
   input  word_t      hp0_rdata_i,
   input  logic [1:0] hp0_rresp_i,
   input  logic       hp0_rvalid_i,
   output logic       hp0_rready_o,

   output logic       resp_done_o,
   output logic       resp_v_o,
   output word_t      resp_data_o,
   output logic [3:0] resp_count_o,
   input  logic       resp_pop_i
);

   localparam int PTR_W = $clog2(RESP_FIFO_DEPTH);
   localparam int CNT_W = PTR_W + 1;

   word_t            mem [RESP_FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] cnt;
   logic             room;
   logic             push;
   word_t            push_data;

   assign room = (cnt != CNT_W'(RESP_FIFO_DEPTH));
   assign push = room & (hp0_bvalid_i | hp0_rvalid_i);

   // read data as is, write status zero-extended
   assign push_data = hp0_rvalid_i ? hp0_rdata_i : word_t'(hp0_bresp_i);

   always_ff @(posedge aclk_i) begin
      if (push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge aclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         cnt    <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (resp_pop_i) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         cnt <= cnt + CNT_W'(push) - CNT_W'(resp_pop_i);
      end
   end

   assign hp0_bready_o = room;
   assign hp0_rready_o = room;
   assign resp_done_o  = push;
   assign resp_v_o     = (cnt != '0);
   assign resp_data_o  = mem[rd_ptr];
   assign resp_count_o = 4'(cnt);

   a_no_empty_pop: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      resp_pop_i |-> resp_v_o);
   // read errors from dram are not reported to the host
   a_rresp_okay: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      hp0_rvalid_i && hp0_rready_o |-> hp0_rresp_i == RESP_OKAY);

endmodule

`default_nettype wire

// File: verilog/dram_req_issue.sv
`timescale 1ns/1ps
`default_nettype none

module dram_req_issue
   import zynq_bridge_pkg::*;
(
   input  logic       aclk_i,
   input  logic       rst_n_i,

   input  logic       req_v_i,
   input  req_type_t  req_type_i,
   input  dram_addr_t req_addr_i,
   input  word_t      req_data_i,
   input  dram_addr_t base_i,
   output logic       req_yumi_o,

   output dram_addr_t hp0_awaddr_o,
   output logic       hp0_awvalid_o,
   input  logic       hp0_awready_i,
   output word_t      hp0_wdata_o,
   output logic       hp0_wvalid_o,
   input  logic       hp0_wready_i,
   output dram_addr_t hp0_araddr_o,
   output logic       hp0_arvalid_o,
   input  logic       hp0_arready_i,

   input  logic       resp_done_i
);

   issue_state_e state_r;
   dram_addr_t   addr_r;
   word_t        data_r;
   logic         awvalid_r;
   logic         wvalid_r;
   logic         arvalid_r;
   logic         aw_done;
   logic         w_done;

   // take the fifo heads as we leave idle
   assign req_yumi_o = (state_r == ISSUE_IDLE) & req_v_i;

   // channel finished or finishing this cycle
   assign aw_done = ~awvalid_r | hp0_awready_i;
   assign w_done  = ~wvalid_r | hp0_wready_i;

   always_ff @(posedge aclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_r   <= ISSUE_IDLE;
         awvalid_r <= 1'b0;
         wvalid_r  <= 1'b0;
         arvalid_r <= 1'b0;
      end else begin
         case (state_r)
            ISSUE_IDLE: begin
               if (req_v_i) begin
                  if (req_type_i == REQ_WRITE) begin
                     awvalid_r <= 1'b1;
                     wvalid_r  <= 1'b1;
                     state_r   <= ISSUE_WRITE_ADDR_DATA;
                  end else begin
                     arvalid_r <= 1'b1;
                     state_r   <= ISSUE_READ_ADDR;
                  end
               end
            end
            ISSUE_WRITE_ADDR_DATA: begin
               // aw and w may complete in either order
               if (hp0_awready_i) begin
                  awvalid_r <= 1'b0;
               end
               if (hp0_wready_i) begin
                  wvalid_r <= 1'b0;
               end
               if (aw_done && w_done) begin
                  state_r <= ISSUE_WAIT_RESP;
               end
            end
            ISSUE_READ_ADDR: begin
               if (hp0_arready_i) begin
                  arvalid_r <= 1'b0;
                  state_r   <= ISSUE_WAIT_RESP;
               end
            end
            ISSUE_WAIT_RESP: begin
               if (resp_done_i) begin
                  state_r <= ISSUE_IDLE;
               end
            end
            default: state_r <= ISSUE_IDLE;
         endcase
      end
   end

   always_ff @(posedge aclk_i) begin
      if (req_yumi_o) begin
         addr_r <= base_i + req_addr_i;
         data_r <= req_data_i;
      end
   end

   assign hp0_awaddr_o  = addr_r;
   assign hp0_awvalid_o = awvalid_r;
   assign hp0_wdata_o   = data_r;
   assign hp0_wvalid_o  = wvalid_r;
   assign hp0_araddr_o  = addr_r;
   assign hp0_arvalid_o = arvalid_r;

   ////////////////////////////////////////
   // hp0 protocol checks
   ////////////////////////////////////////
   a_aw_hold: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      hp0_awvalid_o && !hp0_awready_i |=> hp0_awvalid_o && $stable(hp0_awaddr_o));
   a_w_hold: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      hp0_wvalid_o && !hp0_wready_i |=> hp0_wvalid_o && $stable(hp0_wdata_o));
   a_ar_hold: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      hp0_arvalid_o && !hp0_arready_i |=> hp0_arvalid_o && $stable(hp0_araddr_o));
   a_aw_ar_excl: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      !(hp0_awvalid_o && hp0_arvalid_o));

endmodule

`default_nettype wire

// File: verilog/zynq_pl_shell.sv
`timescale 1ns/1ps
`default_nettype none

module zynq_pl_shell
   import zynq_bridge_pkg::*;
#(
   parameter int REQ_FIFO_DEPTH = 4
) (
   input  logic       aclk_i,
   input  logic       rst_n_i,

   input  gp0_addr_t  gp0_awaddr_i,
   input  logic       gp0_awvalid_i,
   output logic       gp0_awready_o,
   input  word_t      gp0_wdata_i,
   input  logic       gp0_wvalid_i,
   output logic       gp0_wready_o,
   output logic [1:0] gp0_bresp_o,
   output logic       gp0_bvalid_o,
   input  logic       gp0_bready_i,
   input  gp0_addr_t  gp0_araddr_i,
   input  logic       gp0_arvalid_i,
   output logic       gp0_arready_o,
   output word_t      gp0_rdata_o,
   output logic [1:0] gp0_rresp_o,
   output logic       gp0_rvalid_o,
   input  logic       gp0_rready_i,

   output logic       req_v_o,
   output req_type_t  req_type_o,
   output dram_addr_t req_addr_o,
   output word_t      req_data_o,
   input  logic       req_yumi_i,
   output dram_addr_t base_o,

   input  logic       resp_v_i,
   input  word_t      resp_data_i,
   input  logic [3:0] resp_count_i,
   output logic       resp_pop_o
);

   localparam int PTR_W     = $clog2(REQ_FIFO_DEPTH);
   localparam int CNT_W     = PTR_W + 1;
   localparam int NUM_FIFOS = 3;
   localparam int FIFO_TYPE = 0;
   localparam int FIFO_ADDR = 1;
   localparam int FIFO_DATA = 2;

   logic                 awready_r;
   logic                 bvalid_r;
   logic [1:0]           bresp_r;
   logic                 arready_r;
   logic                 rvalid_r;
   word_t                rdata_r;
   word_t                rd_mux;
   dram_addr_t           base_r;
   logic                 wr_en;
   logic                 rd_en;
   logic [NUM_FIFOS-1:0] wr_sel;
   logic [NUM_FIFOS-1:0] fifo_push;
   logic [NUM_FIFOS-1:0] fifo_full;
   logic [NUM_FIFOS-1:0] fifo_empty;

   word_t                fifo_mem [NUM_FIFOS][REQ_FIFO_DEPTH];
   logic [PTR_W-1:0]     wr_ptr [NUM_FIFOS];
   logic [CNT_W-1:0]     fifo_cnt [NUM_FIFOS];
   // all three pop together so one read pointer serves them
   logic [PTR_W-1:0]     rd_ptr;

   ////////////////////////////////////////
   // gp0 write side
   ////////////////////////////////////////
   assign wr_en = awready_r & gp0_awvalid_i & gp0_wvalid_i;

   always_ff @(posedge aclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         awready_r <= 1'b0;
         bvalid_r  <= 1'b0;
         bresp_r   <= RESP_OKAY;
      end else begin
         // aw and w taken together, one transfer at a time
         awready_r <= gp0_awvalid_i & gp0_wvalid_i & ~awready_r & ~bvalid_r;
         if (wr_en) begin
            bvalid_r <= 1'b1;
            bresp_r  <= (|(wr_sel & fifo_full)) ? RESP_SLVERR : RESP_OKAY;
         end else if (gp0_bready_i) begin
            bvalid_r <= 1'b0;
         end
      end
   end

   always_ff @(posedge aclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         base_r <= '0;
      end else if (wr_en && gp0_awaddr_i == REG_BASE) begin
         base_r <= gp0_wdata_i;
      end
   end

   always_comb begin
      wr_sel = '0;
      case (gp0_awaddr_i)
         REG_REQ_TYPE: wr_sel[FIFO_TYPE] = 1'b1;
         REG_REQ_ADDR: wr_sel[FIFO_ADDR] = 1'b1;
         REG_REQ_DATA: wr_sel[FIFO_DATA] = 1'b1;
         default:      wr_sel = '0;
      endcase
   end

   // write to a full fifo is dropped
   assign fifo_push = {NUM_FIFOS{wr_en}} & wr_sel & ~fifo_full;

   ////////////////////////////////////////
   // request fifos
   ////////////////////////////////////////
   always_ff @(posedge aclk_i) begin
      for (int i = 0; i < NUM_FIFOS; i++) begin
         if (fifo_push[i]) begin
            fifo_mem[i][wr_ptr[i]] <= gp0_wdata_i;
         end
      end
   end

   always_ff @(posedge aclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rd_ptr <= '0;
         for (int i = 0; i < NUM_FIFOS; i++) begin
            wr_ptr[i]   <= '0;
            fifo_cnt[i] <= '0;
         end
      end else begin
         if (req_yumi_i) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         for (int i = 0; i < NUM_FIFOS; i++) begin
            if (fifo_push[i]) begin
               wr_ptr[i] <= wr_ptr[i] + 1'b1;
            end
            fifo_cnt[i] <= fifo_cnt[i] + CNT_W'(fifo_push[i]) - CNT_W'(req_yumi_i);
         end
      end
   end

   for (genvar g = 0; g < NUM_FIFOS; g++) begin : g_flags
      assign fifo_full[g]  = (fifo_cnt[g] == CNT_W'(REQ_FIFO_DEPTH));
      assign fifo_empty[g] = (fifo_cnt[g] == '0);

      // occupancy stays bounded across any mix of pushes and pops
      a_cnt_bound: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
         fifo_cnt[g] <= CNT_W'(REQ_FIFO_DEPTH));
   end

   assign req_v_o    = ~|fifo_empty;
   assign req_type_o = req_type_t'(fifo_mem[FIFO_TYPE][rd_ptr][0]);
   assign req_addr_o = fifo_mem[FIFO_ADDR][rd_ptr];
   assign req_data_o = fifo_mem[FIFO_DATA][rd_ptr];
   assign base_o     = base_r;

   ////////////////////////////////////////
   // gp0 read side
   ////////////////////////////////////////
   assign rd_en      = arready_r & gp0_arvalid_i;
   assign resp_pop_o = rd_en & (gp0_araddr_i == REG_RESP) & resp_v_i;

   always_comb begin
      case (gp0_araddr_i)
         REG_BASE:   rd_mux = base_r;
         // empty queue reads as zero
         REG_RESP:   rd_mux = resp_v_i ? resp_data_i : '0;
         REG_STATUS: rd_mux = {24'b0, resp_count_i, 3'b0, resp_v_i};
         default:    rd_mux = '0;
      endcase
   end

   always_ff @(posedge aclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         arready_r <= 1'b0;
         rvalid_r  <= 1'b0;
      end else begin
         arready_r <= gp0_arvalid_i & ~arready_r & ~rvalid_r;
         if (rd_en) begin
            rvalid_r <= 1'b1;
         end else if (gp0_rready_i) begin
            rvalid_r <= 1'b0;
         end
      end
   end

   always_ff @(posedge aclk_i) begin
      if (rd_en) begin
         rdata_r <= rd_mux;
      end
   end

   assign gp0_awready_o = awready_r;
   assign gp0_wready_o  = awready_r;
   assign gp0_bvalid_o  = bvalid_r;
   assign gp0_bresp_o   = bresp_r;
   assign gp0_arready_o = arready_r;
   assign gp0_rvalid_o  = rvalid_r;
   assign gp0_rdata_o   = rdata_r;
   assign gp0_rresp_o   = RESP_OKAY;

   // issuer only takes a request the shell offers
   a_yumi_v: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      req_yumi_i |-> req_v_o);

endmodule

`default_nettype wire

// File: verilog/zynq_bridge_pkg.sv
`default_nettype none

package zynq_bridge_pkg;

   ////////////////////////////////////////
   // widths
   ////////////////////////////////////////
   typedef logic [9:0]  gp0_addr_t;
   typedef logic [31:0] word_t;
   typedef logic [31:0] dram_addr_t;
   typedef logic [0:0]  req_type_t;

   // request kinds
   localparam req_type_t REQ_WRITE = 1'b0;
   localparam req_type_t REQ_READ  = 1'b1;

   // axi response codes
   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   ////////////////////////////////////////
   // gp0 register map
   ////////////////////////////////////////
   localparam gp0_addr_t REG_BASE     = 10'h000;
   localparam gp0_addr_t REG_REQ_TYPE = 10'h004;
   localparam gp0_addr_t REG_REQ_ADDR = 10'h008;
   // pushing data completes a request
   localparam gp0_addr_t REG_REQ_DATA = 10'h00C;
   localparam gp0_addr_t REG_RESP     = 10'h010;
   localparam gp0_addr_t REG_STATUS   = 10'h014;

   typedef enum logic [1:0] {
      ISSUE_IDLE,
      ISSUE_WRITE_ADDR_DATA,
      ISSUE_READ_ADDR,
      ISSUE_WAIT_RESP
   } issue_state_e;

endpackage

`default_nettype wire
